// ==== src.f ====
design/systolic_pkg.sv
design/proc_element.sv
design/pe_array.sv
design/operand_skew.sv
design/array_sequencer.sv
design/matmul_top.sv
testbench/matmul_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the matrix multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module matmul_tb \
    -f src.f \
    -o matmul_sim

./obj_dir/matmul_sim 2>&1 | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== testbench/matmul_tb.sv ====
`timescale 1ns/1ps

module matmul_tb import systolic_pkg::*; ();

    typedef enum logic [1:0] {
        kind_identity,
        kind_random,
        kind_zero,
        kind_max
    } mat_kind_t;

    typedef struct packed {
        mat_kind_t kind;
        logic      second_start;
        logic      mid_reset;
    } test_entry_t;

    localparam int num_tests = 6;
    localparam int wait_limit = 64;
    // compute phase plus the read cycle, less the feed cycles already spent
    localparam int valid_wait = compute_cycles + 1 - dim;

    // zero entry follows a nonzero one so stale accumulators would show
    test_entry_t test_table [num_tests] = '{
        '{kind_identity, 1'b0, 1'b0},
        '{kind_random,   1'b0, 1'b0},
        '{kind_zero,     1'b0, 1'b0},
        '{kind_random,   1'b1, 1'b0},
        '{kind_max,      1'b0, 1'b0},
        '{kind_random,   1'b0, 1'b1}
    };

    logic      clk;
    logic      rst;
    logic      start;
    data_row_t a_col;
    data_row_t b_row;
    data_row_t c_row;
    logic      c_valid;
    logic      done;

    data_t a_mat [dim][dim];
    data_t b_mat [dim][dim];
    data_t c_exp [dim][dim];
    data_t c_got [dim][dim];

    integer seed = 32'h16bfa1d6;
    int     errors;
    int     test_errors;
    int     tests_run;
    int     tests_passed;
    bit     timed_out;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    matmul_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .a_col   (a_col),
        .b_row   (b_row),
        .c_row   (c_row),
        .c_valid (c_valid),
        .done    (done)
    );

    task automatic fill_matrices(input mat_kind_t kind);
        for (int i = 0; i < dim; i++) begin
            for (int j = 0; j < dim; j++) begin
                case (kind)
                    kind_identity: begin
                        a_mat[i][j] = (i == j) ? 32'd1 : 32'd0;
                        b_mat[i][j] = $random(seed);
                    end
                    kind_random: begin
                        a_mat[i][j] = $random(seed);
                        b_mat[i][j] = $random(seed);
                    end
                    kind_zero: begin
                        a_mat[i][j] = '0;
                        b_mat[i][j] = '0;
                    end
                    default: begin
                        a_mat[i][j] = '1;
                        b_mat[i][j] = '1;
                    end
                endcase
            end
        end
    endtask

    // reference product, sums wrap at 32 bits
    task automatic compute_model();
        data_t sum;
        for (int i = 0; i < dim; i++) begin
            for (int j = 0; j < dim; j++) begin
                sum = '0;
                for (int k = 0; k < dim; k++) begin
                    sum = sum + a_mat[i][k] * b_mat[k][j];
                end
                c_exp[i][j] = sum;
            end
        end
    endtask

    // start pulse, then slice k of A and B on each following edge
    task automatic feed_operands(input logic second_start, input int slices);
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int k = 0; k < slices; k++) begin
            for (int i = 0; i < dim; i++) begin
                a_col[i] = a_mat[i][k];
                b_row[i] = b_mat[k][i];
            end
            // stray start while the array computes
            start = second_start && (k == 2);
            @(negedge clk);
        end
        start = 1'b0;
        a_col = '0;
        b_row = '0;
    endtask

    task automatic abort_with_reset();
        feed_operands(1'b0, 2);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < 3 * compute_cycles; n++) begin
            @(negedge clk);
            assert (c_valid == 1'b0)
            else begin
                $display("error %0t c_valid: got %b, expected 0", $time, c_valid);
                test_errors++;
            end
            assert (done == 1'b0)
            else begin
                $display("error %0t done: got %b, expected 0", $time, done);
                test_errors++;
            end
        end
    endtask

    task automatic wait_for_valid(output bit ok, output int cycles);
        int n;
        n = 0;
        while (!c_valid && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        ok     = c_valid;
        cycles = n;
    endtask

    // first valid row is row 4 of C
    task automatic collect_rows(output int rows);
        rows = 0;
        while (c_valid && rows < 2 * dim) begin
            if (rows < dim) begin
                for (int j = 0; j < dim; j++) begin
                    c_got[dim-1-rows][j] = c_row[j];
                end
            end
            rows++;
            @(negedge clk);
        end
    endtask

    task automatic wait_for_done(output bit ok, output int cycles);
        int n;
        n = 0;
        while (!done && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        ok     = done;
        cycles = n;
    endtask

    task automatic check_results();
        for (int i = 0; i < dim; i++) begin
            for (int j = 0; j < dim; j++) begin
                assert (c_got[i][j] == c_exp[i][j])
                else begin
                    $display("error %0t c_row[%0d] (C[%0d][%0d]): got %h, expected %h",
                             $time, j, i, j, c_got[i][j], c_exp[i][j]);
                    test_errors++;
                end
            end
        end
    endtask

    task automatic run_test(input int idx, input test_entry_t entry);
        bit ok;
        int rows;
        int waited;
        test_errors = 0;
        tests_run++;
        fill_matrices(entry.kind);
        compute_model();
        if (entry.mid_reset) begin
            abort_with_reset();
        end
        feed_operands(entry.second_start, dim);
        wait_for_valid(ok, waited);
        if (!ok) begin
            $display("test %0d: c_valid did not rise within %0d cycles", idx, wait_limit);
            timed_out = 1'b1;
            return;
        end
        assert (waited == valid_wait)
        else begin
            $display("error %0t c_valid latency: got %0d, expected %0d",
                     $time, waited, valid_wait);
            test_errors++;
        end
        collect_rows(rows);
        assert (rows == dim)
        else begin
            $display("error %0t c_valid cycles: got %0d, expected %0d", $time, rows, dim);
            test_errors++;
        end
        wait_for_done(ok, waited);
        if (!ok) begin
            $display("test %0d: done did not pulse within %0d cycles", idx, wait_limit);
            timed_out = 1'b1;
            return;
        end
        // done belongs to the cycle right after the last valid row
        assert (waited == 0)
        else begin
            $display("error %0t done delay: got %0d, expected 0", $time, waited);
            test_errors++;
        end
        @(negedge clk);
        assert (done == 1'b0)
        else begin
            $display("error %0t done: got %b, expected 0", $time, done);
            test_errors++;
        end
        check_results();
        errors += test_errors;
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: ok", idx, entry.kind.name());
        end else begin
            $display("test %0d %s: %0d errors", idx, entry.kind.name(), test_errors);
        end
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        a_col        = '0;
        b_row        = '0;
        errors       = 0;
        tests_run    = 0;
        tests_passed = 0;
        timed_out    = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int t = 0; t < num_tests && !timed_out; t++) begin
            run_test(t, test_table[t]);
        end
        $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, errors);
        if (errors == 0 && !timed_out) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== design/matmul_top.sv ====
`timescale 1ns/1ps

module matmul_top import systolic_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  data_row_t a_col,
    input  data_row_t b_row,
    output data_row_t c_row,
    output logic      c_valid,
    output logic      done
);

    logic      feed_en;
    pe_ctrl_t  pe_ctrl;
    data_row_t a_skewed;
    data_row_t b_skewed;

    array_sequencer u_seq (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .feed_en (feed_en),
        .c_valid (c_valid),
        .done    (done),
        .pe_ctrl (pe_ctrl)
    );

    operand_skew u_skew (
        .clk      (clk),
        .rst      (rst),
        .feed_en  (feed_en),
        .a_col    (a_col),
        .b_row    (b_row),
        .a_skewed (a_skewed),
        .b_skewed (b_skewed)
    );

    // rows of C leave the bottom edge, row 4 first
    pe_array u_array (
        .clk      (clk),
        .rst      (rst),
        .ctrl     (pe_ctrl),
        .a_left   (a_skewed),
        .b_top    (b_skewed),
        .b_bottom (c_row)
    );

endmodule

// ==== design/array_sequencer.sv ====
`timescale 1ns/1ps

module array_sequencer import systolic_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    output logic     feed_en,
    output logic     c_valid,
    output logic     done,
    output pe_ctrl_t pe_ctrl
);

    seq_state_t state;
    logic [3:0] cycle_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= idle;
            cycle_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        state     <= compute;
                        cycle_cnt <= '0;
                    end
                end
                compute: begin
                    if (cycle_cnt == 4'(compute_cycles - 1)) begin
                        state     <= read_out;
                        cycle_cnt <= '0;
                    end else begin
                        cycle_cnt <= cycle_cnt + 4'd1;
                    end
                end
                read_out: begin
                    state     <= drain;
                    cycle_cnt <= '0;
                end
                drain: begin
                    if (cycle_cnt == 4'(dim - 1)) begin
                        state <= idle;
                        done  <= 1'b1;
                    end else begin
                        cycle_cnt <= cycle_cnt + 4'd1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // first dim compute cycles carry operand slices
    assign feed_en = (state == compute) && (cycle_cnt < 4'(dim));

    // B outputs hold results once the read edge has passed
    assign c_valid = (state == drain);

    always_comb begin
        pe_ctrl       = '0;
        pe_ctrl.clr   = (state == idle);
        pe_ctrl.read  = (state == read_out);
        pe_ctrl.write = (state == drain);
    end

    // valid window is dim cycles long, done right after it
    assert property (@(posedge clk) disable iff (rst)
        $rose(c_valid) |-> ##dim (!c_valid && done))
    else $error("array_sequencer: c_valid window or done pulse misplaced");

    // a fresh run would show as compute with a zero count
    assert property (@(posedge clk) disable iff (rst)
        (start && state != idle) |=> !(state == compute && cycle_cnt == '0))
    else $error("array_sequencer: start restarted a run in progress");

endmodule

// ==== design/operand_skew.sv ====
`timescale 1ns/1ps

module operand_skew import systolic_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      feed_en,
    input  data_row_t a_col,
    input  data_row_t b_row,
    output data_row_t a_skewed,
    output data_row_t b_skewed
);

    data_row_t a_q;
    data_row_t b_q;

    // input stage, zeros outside the feed window
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
        end else begin
            a_q <= feed_en ? a_col : '0;
            b_q <= feed_en ? b_row : '0;
        end
    end

    for (genvar i = 0; i < dim; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign a_skewed[i] = a_q[i];
            assign b_skewed[i] = b_q[i];
        end else begin : g_delay
            // lane i waits i extra cycles
            data_t a_sr [i];
            data_t b_sr [i];

            always_ff @(posedge clk or posedge rst) begin
                if (rst) begin
                    for (int k = 0; k < i; k++) begin
                        a_sr[k] <= '0;
                        b_sr[k] <= '0;
                    end
                end else begin
                    a_sr[0] <= a_q[i];
                    b_sr[0] <= b_q[i];
                    for (int k = 1; k < i; k++) begin
                        a_sr[k] <= a_sr[k-1];
                        b_sr[k] <= b_sr[k-1];
                    end
                end
            end

            assign a_skewed[i] = a_sr[i-1];
            assign b_skewed[i] = b_sr[i-1];
        end
    end

endmodule

// ==== design/pe_array.sv ====
`timescale 1ns/1ps

module pe_array import systolic_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  pe_ctrl_t  ctrl,
    input  data_row_t a_left,
    input  data_row_t b_top,
    output data_row_t b_bottom
);

    // horizontal links, a_link[i][j] feeds PE(i,j)
    data_t a_link [dim][dim+1];
    // vertical links, b_link[i][j] feeds PE(i,j)
    data_t b_link [dim+1][dim];

    for (genvar i = 0; i < dim; i++) begin : g_row_edge
        assign a_link[i][0] = a_left[i];
    end

    for (genvar j = 0; j < dim; j++) begin : g_col_edge
        assign b_link[0][j] = b_top[j];
        // same chain carries operands and then results
        assign b_bottom[j]  = b_link[dim][j];
    end

    // a_link[i][dim] leaves the right edge unused
    for (genvar i = 0; i < dim; i++) begin : g_row
        for (genvar j = 0; j < dim; j++) begin : g_col
            proc_element u_pe (
                .clk   (clk),
                .rst   (rst),
                .a_in  (a_link[i][j]),
                .b_in  (b_link[i][j]),
                .ctrl  (ctrl),
                .a_out (a_link[i][j+1]),
                .b_out (b_link[i+1][j])
            );
        end
    end

endmodule

// ==== design/proc_element.sv ====
`timescale 1ns/1ps

module proc_element import systolic_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  data_t    a_in,
    input  data_t    b_in,
    input  pe_ctrl_t ctrl,
    output data_t    a_out,
    output data_t    b_out
);

    data_t acc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (ctrl.clr) begin
            acc   <= '0;
            a_out <= '0;
            b_out <= '0;
        end else if (ctrl.read) begin
            // result onto the column chain
            b_out <= acc;
        end else if (ctrl.write) begin
            // drain, shift the column down by one
            b_out <= b_in;
        end else begin
            // product wraps to 32 bits
            acc   <= acc + a_in * b_in;
            a_out <= a_in;
            b_out <= b_in;
        end
    end

    // the sequencer must never issue two commands at once
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({ctrl.clr, ctrl.read, ctrl.write}))
    else $error("proc_element: conflicting control bits %b", ctrl);

endmodule

// ==== design/systolic_pkg.sv ====
package systolic_pkg;

    // array edge, 5x5 only
    localparam int dim = 5;
    localparam int data_w = 32;

    // 5 feed + 8 skew/propagation + 1 margin
    localparam int compute_cycles = 14;

    typedef logic [data_w-1:0] data_t;

    // one column of A, one row of B or one row of C
    typedef data_t [dim-1:0] data_row_t;

    // broadcast to every PE, at most one bit set
    typedef struct packed {
        logic clr;
        logic read;
        logic write;
    } pe_ctrl_t;

    typedef enum logic [1:0] {
        idle,
        compute,
        read_out,
        drain
    } seq_state_t;

endpackage
